// ==== rtl/valu_pkg.sv ====
`default_nettype none

package valu_pkg;

    // Register geometry
    localparam int VLEN  = 64;
    localparam int VLENB = VLEN / 8;

    typedef logic [VLEN-1:0]  vreg_t;
    typedef logic [VLENB-1:0] mask_t;
    typedef logic [4:0]       regaddr_t;
    typedef logic [5:0]       funct6_t;
    typedef logic [2:0]       funct3_t;
    typedef logic [31:0]      insn_t;

    // OP-V major opcode and the two supported operand categories
    localparam logic [6:0] OPCODE_OPV = 7'b1010111;
    localparam funct3_t    F3_OPIVV   = 3'b000;
    localparam funct3_t    F3_OPMVV   = 3'b010;

    // vtype.vsew, codes 011 and up are reserved here
    typedef enum logic [2:0] {
        EW8  = 3'b000,
        EW16 = 3'b001,
        EW32 = 3'b010
    } sew_e;

    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_RSUB,
        OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA,
        OP_MINU, OP_MIN, OP_MAXU, OP_MAX,
        OP_MSEQ, OP_MSNE, OP_MSLTU, OP_MSLT,
        OP_MSLEU, OP_MSLE, OP_MSGTU, OP_MSGT,
        OP_MUL, OP_MULH, OP_MULHU, OP_MULHSU,
        OP_ILLEGAL
    } valu_op_e;

    // Decode to execute
    typedef struct packed {
        valu_op_e op;
        sew_e     sew;
        vreg_t    vs2;
        vreg_t    vs1;
        vreg_t    vd_old;
        regaddr_t vd_addr;
        logic     illegal;
    } valu_req_t;

    // Execute to writeback
    typedef struct packed {
        vreg_t    data;
        mask_t    mask;
        logic     is_mask;
        logic     illegal;
        regaddr_t vd_addr;
        vreg_t    vd_old;
    } valu_res_t;

endpackage

`default_nettype wire

// ==== rtl/valu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module valu_decode (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                valid_i,
    input  valu_pkg::insn_t     insn_i,
    input  valu_pkg::sew_e      vsew_i,
    input  valu_pkg::vreg_t     vs2_i,
    input  valu_pkg::vreg_t     vs1_i,
    input  valu_pkg::vreg_t     vd_old_i,
    output logic                req_valid_o,
    output valu_pkg::valu_req_t req_o
);
    import valu_pkg::*;

    funct6_t  f6;
    funct3_t  f3;
    valu_op_e op;
    logic     opcode_ok;
    logic     sew_ok;
    logic     mul_sew_bad;
    logic     illegal;

    assign f6 = insn_i[31:26];
    assign f3 = insn_i[14:12];

    // funct6 tables for OPIVV and OPMVV
    always_comb begin
        op = OP_ILLEGAL;
        if (f3 == F3_OPIVV) begin
            case (f6)
                6'b000000: op = OP_ADD;
                6'b000010: op = OP_SUB;
                6'b000011: op = OP_RSUB;
                6'b000100: op = OP_MINU;
                6'b000101: op = OP_MIN;
                6'b000110: op = OP_MAXU;
                6'b000111: op = OP_MAX;
                6'b001001: op = OP_AND;
                6'b001010: op = OP_OR;
                6'b001011: op = OP_XOR;
                6'b011000: op = OP_MSEQ;
                6'b011001: op = OP_MSNE;
                6'b011010: op = OP_MSLTU;
                6'b011011: op = OP_MSLT;
                6'b011100: op = OP_MSLEU;
                6'b011101: op = OP_MSLE;
                6'b011110: op = OP_MSGTU;
                6'b011111: op = OP_MSGT;
                6'b100101: op = OP_SLL;
                6'b101000: op = OP_SRL;
                6'b101001: op = OP_SRA;
                default:   op = OP_ILLEGAL;
            endcase
        end else if (f3 == F3_OPMVV) begin
            case (f6)
                6'b100100: op = OP_MULHU;
                6'b100101: op = OP_MUL;
                6'b100110: op = OP_MULHSU;
                6'b100111: op = OP_MULH;
                default:   op = OP_ILLEGAL;
            endcase
        end
    end

    assign opcode_ok   = (insn_i[6:0] == OPCODE_OPV);
    assign sew_ok      = vsew_i inside {EW8, EW16, EW32};
    // Multiplier only exists for byte lanes
    assign mul_sew_bad = (op inside {OP_MUL, OP_MULH, OP_MULHU, OP_MULHSU}) && (vsew_i != EW8);
    assign illegal     = !opcode_ok || (op == OP_ILLEGAL) || !sew_ok || mul_sew_bad;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            req_valid_o <= 1'b0;
        end else begin
            req_valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        req_o.op      <= illegal ? OP_ILLEGAL : op;
        req_o.sew     <= vsew_i;
        req_o.vs2     <= vs2_i;
        req_o.vs1     <= vs1_i;
        req_o.vd_old  <= vd_old_i;
        req_o.vd_addr <= insn_i[11:7];
        req_o.illegal <= illegal;
    end

endmodule

`default_nettype wire

// ==== rtl/valu_lanes.sv ====
`timescale 1ns/1ps
`default_nettype none

module valu_lanes (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                req_valid_i,
    input  valu_pkg::valu_req_t req_i,
    output logic                res_valid_o,
    output valu_pkg::valu_res_t res_o
);
    import valu_pkg::*;

    vreg_t    a;
    vreg_t    b;
    valu_op_e op;

    // vs2 is the first operand, vs1 the second
    assign a  = req_i.vs2;
    assign b  = req_i.vs1;
    assign op = req_i.op;

    // Compare outcome from the equal and greater-than terms
    function automatic logic cmp_sel(valu_op_e f_op, logic eq, logic gtu, logic gts);
        case (f_op)
            OP_MSNE:  return !eq;
            OP_MSLTU: return !eq && !gtu;
            OP_MSLT:  return !eq && !gts;
            OP_MSLEU: return !gtu;
            OP_MSLE:  return !gts;
            OP_MSGTU: return gtu;
            OP_MSGT:  return gts;
            default:  return eq;
        endcase
    endfunction

    // High when min/max keeps the vs2 element
    function automatic logic keep_a(valu_op_e f_op, logic gtu, logic gts);
        case (f_op)
            OP_MINU: return !gtu;
            OP_MIN:  return !gts;
            OP_MAXU: return gtu;
            default: return gts;
        endcase
    endfunction

////////////////////////////////////////////////////////////////////////////
// Add / subtract
////////////////////////////////////////////////////////////////////////////

    logic  do_sub;
    vreg_t sum_a;
    vreg_t sum_b;
    vreg_t add_8;
    vreg_t add_16;
    vreg_t add_32;

    assign do_sub = op inside {OP_SUB, OP_RSUB};
    assign sum_a  = (op == OP_RSUB) ? b : a;
    // Invert and add one per lane, carry stays inside the element
    assign sum_b  = (op == OP_RSUB) ? ~a : (do_sub ? ~b : b);

    always_comb begin
        for (int i = 0; i < VLENB; i++)
            add_8[8*i +: 8] = sum_a[8*i +: 8] + sum_b[8*i +: 8] + {7'b0, do_sub};
        for (int i = 0; i < VLENB/2; i++)
            add_16[16*i +: 16] = sum_a[16*i +: 16] + sum_b[16*i +: 16] + {15'b0, do_sub};
        for (int i = 0; i < VLENB/4; i++)
            add_32[32*i +: 32] = sum_a[32*i +: 32] + sum_b[32*i +: 32] + {31'b0, do_sub};
    end

////////////////////////////////////////////////////////////////////////////
// Shifts, compares and min/max
////////////////////////////////////////////////////////////////////////////

    vreg_t sll_8, srl_8, sra_8, mm_8;
    vreg_t sll_16, srl_16, sra_16, mm_16;
    vreg_t sll_32, srl_32, sra_32, mm_32;
    logic [VLENB-1:0]   cmp_8;
    logic [VLENB/2-1:0] cmp_16;
    logic [VLENB/4-1:0] cmp_32;

    always_comb begin
        for (int i = 0; i < VLENB; i++) begin
            sll_8[8*i +: 8] = a[8*i +: 8] << b[8*i +: 3];
            srl_8[8*i +: 8] = a[8*i +: 8] >> b[8*i +: 3];
            sra_8[8*i +: 8] = $signed(a[8*i +: 8]) >>> b[8*i +: 3];
            cmp_8[i] = cmp_sel(op, a[8*i +: 8] == b[8*i +: 8], a[8*i +: 8] > b[8*i +: 8],
                               $signed(a[8*i +: 8]) > $signed(b[8*i +: 8]));
            mm_8[8*i +: 8] = keep_a(op, a[8*i +: 8] > b[8*i +: 8],
                                    $signed(a[8*i +: 8]) > $signed(b[8*i +: 8]))
                             ? a[8*i +: 8] : b[8*i +: 8];
        end
        for (int i = 0; i < VLENB/2; i++) begin
            sll_16[16*i +: 16] = a[16*i +: 16] << b[16*i +: 4];
            srl_16[16*i +: 16] = a[16*i +: 16] >> b[16*i +: 4];
            sra_16[16*i +: 16] = $signed(a[16*i +: 16]) >>> b[16*i +: 4];
            cmp_16[i] = cmp_sel(op, a[16*i +: 16] == b[16*i +: 16], a[16*i +: 16] > b[16*i +: 16],
                                $signed(a[16*i +: 16]) > $signed(b[16*i +: 16]));
            mm_16[16*i +: 16] = keep_a(op, a[16*i +: 16] > b[16*i +: 16],
                                       $signed(a[16*i +: 16]) > $signed(b[16*i +: 16]))
                                ? a[16*i +: 16] : b[16*i +: 16];
        end
        for (int i = 0; i < VLENB/4; i++) begin
            sll_32[32*i +: 32] = a[32*i +: 32] << b[32*i +: 5];
            srl_32[32*i +: 32] = a[32*i +: 32] >> b[32*i +: 5];
            sra_32[32*i +: 32] = $signed(a[32*i +: 32]) >>> b[32*i +: 5];
            cmp_32[i] = cmp_sel(op, a[32*i +: 32] == b[32*i +: 32], a[32*i +: 32] > b[32*i +: 32],
                                $signed(a[32*i +: 32]) > $signed(b[32*i +: 32]));
            mm_32[32*i +: 32] = keep_a(op, a[32*i +: 32] > b[32*i +: 32],
                                       $signed(a[32*i +: 32]) > $signed(b[32*i +: 32]))
                                ? a[32*i +: 32] : b[32*i +: 32];
        end
    end

////////////////////////////////////////////////////////////////////////////
// Byte multiply
////////////////////////////////////////////////////////////////////////////

    logic  sign_a;
    logic  sign_b;
    vreg_t mul_res;

    // vmulh treats both as signed, vmulhsu only vs2
    assign sign_a = op inside {OP_MULH, OP_MULHSU};
    assign sign_b = (op == OP_MULH);

    always_comb begin
        for (int i = 0; i < VLENB; i++) begin
            automatic logic signed [17:0] prod;
            prod = $signed({sign_a & a[8*i+7], a[8*i +: 8]})
                 * $signed({sign_b & b[8*i+7], b[8*i +: 8]});
            mul_res[8*i +: 8] = (op == OP_MUL) ? prod[7:0] : prod[15:8];
        end
    end

////////////////////////////////////////////////////////////////////////////
// Width and result select
////////////////////////////////////////////////////////////////////////////

    vreg_t data;
    mask_t mask;
    vreg_t add_r, sll_r, srl_r, sra_r, mm_r;
    vreg_t body_en;

    always_comb begin
        case (req_i.sew)
            EW8: begin
                {add_r, sll_r, srl_r, sra_r, mm_r} = {add_8, sll_8, srl_8, sra_8, mm_8};
                mask    = cmp_8;
                body_en = vreg_t'(8'hFF);
            end
            EW16: begin
                {add_r, sll_r, srl_r, sra_r, mm_r} = {add_16, sll_16, srl_16, sra_16, mm_16};
                mask    = {4'b0, cmp_16};
                body_en = vreg_t'(8'h0F);
            end
            default: begin
                {add_r, sll_r, srl_r, sra_r, mm_r} = {add_32, sll_32, srl_32, sra_32, mm_32};
                mask    = {6'b0, cmp_32};
                body_en = vreg_t'(8'h03);
            end
        endcase
    end

    // For compares the data field carries which mask bits are elements
    always_comb begin
        case (op)
            OP_AND:                                    data = a & b;
            OP_OR:                                     data = a | b;
            OP_XOR:                                    data = a ^ b;
            OP_SLL:                                    data = sll_r;
            OP_SRL:                                    data = srl_r;
            OP_SRA:                                    data = sra_r;
            OP_MINU, OP_MIN, OP_MAXU, OP_MAX:          data = mm_r;
            OP_MUL, OP_MULH, OP_MULHU, OP_MULHSU:      data = mul_res;
            OP_MSEQ, OP_MSNE, OP_MSLTU, OP_MSLT,
            OP_MSLEU, OP_MSLE, OP_MSGTU, OP_MSGT:      data = body_en;
            default:                                   data = add_r;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        res_o.data    <= data;
        res_o.mask    <= mask;
        res_o.is_mask <= op inside {[OP_MSEQ:OP_MSGT]};
        res_o.illegal <= req_i.illegal;
        res_o.vd_addr <= req_i.vd_addr;
        res_o.vd_old  <= req_i.vd_old;
    end

endmodule

`default_nettype wire

// ==== rtl/valu_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

module valu_writeback (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                res_valid_i,
    input  valu_pkg::valu_res_t res_i,
    output logic                valid_o,
    output logic                illegal_o,
    output valu_pkg::regaddr_t  vd_addr_o,
    output valu_pkg::vreg_t     vd_data_o
);
    import valu_pkg::*;

    vreg_t merged;
    vreg_t vd_next;

    // Mask body replaces old vd bits, tail stays undisturbed
    always_comb begin
        merged = res_i.vd_old;
        for (int i = 0; i < VLENB; i++) begin
            if (res_i.data[i]) begin
                merged[i] = res_i.mask[i];
            end
        end
    end

    always_comb begin
        if (res_i.illegal) begin
            vd_next = '0;
        end else if (res_i.is_mask) begin
            vd_next = merged;
        end else begin
            vd_next = res_i.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o   <= 1'b0;
            illegal_o <= 1'b0;
        end else begin
            valid_o   <= res_valid_i;
            illegal_o <= res_valid_i && res_i.illegal;
        end
    end

    always_ff @(posedge clk) begin
        vd_addr_o <= res_i.vd_addr;
        vd_data_o <= vd_next;
    end

endmodule

`default_nettype wire

// ==== rtl/valu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module valu_top (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               valid_i,
    input  valu_pkg::insn_t    insn_i,
    input  valu_pkg::sew_e     vsew_i,
    input  valu_pkg::vreg_t    vs2_i,
    input  valu_pkg::vreg_t    vs1_i,
    input  valu_pkg::vreg_t    vd_old_i,
    output logic               valid_o,
    output logic               illegal_o,
    output valu_pkg::regaddr_t vd_addr_o,
    output valu_pkg::vreg_t    vd_data_o
);
    import valu_pkg::*;

    logic      req_valid;
    valu_req_t req;
    logic      res_valid;
    valu_res_t res;

    // Three registered stages, one instruction per cycle
    valu_decode u_decode (
        .clk         (clk),
        .rst_i       (rst_i),
        .valid_i     (valid_i),
        .insn_i      (insn_i),
        .vsew_i      (vsew_i),
        .vs2_i       (vs2_i),
        .vs1_i       (vs1_i),
        .vd_old_i    (vd_old_i),
        .req_valid_o (req_valid),
        .req_o       (req)
    );

    valu_lanes u_lanes (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid),
        .req_i       (req),
        .res_valid_o (res_valid),
        .res_o       (res)
    );

    valu_writeback u_writeback (
        .clk         (clk),
        .rst_i       (rst_i),
        .res_valid_i (res_valid),
        .res_i       (res),
        .valid_o     (valid_o),
        .illegal_o   (illegal_o),
        .vd_addr_o   (vd_addr_o),
        .vd_data_o   (vd_data_o)
    );

endmodule

`default_nettype wire

// ==== sim/valu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module valu_tb;
    import valu_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int N_DIR       = 40;
    localparam int N_RAND      = 400;
    localparam int WATCHDOG_NS = (N_DIR + N_RAND + 50) * CLK_PERIOD;

    // Edge values, 0x80 against 0x7F and FF plus 01 in byte lanes
    localparam vreg_t DIR_A   = 64'h807F_FF01_8000_7FFF;
    localparam vreg_t DIR_B   = 64'h7F80_0101_7FFF_F901;
    localparam vreg_t VD_FILL = 64'hA5C3_5A3C_0FF0_96E1;
    localparam vreg_t MUL_A   = 64'h80FF_7F02_FE81_0310;
    localparam vreg_t MUL_B   = 64'hFF80_7FFE_0281_FD10;

    typedef struct packed {
        logic        illegal;
        regaddr_t    addr;
        vreg_t       data;
        int unsigned due;
    } expect_t;

    logic     clk;
    logic     rst_i;
    logic     valid_i;
    insn_t    insn;
    sew_e     vsew;
    vreg_t    vs2;
    vreg_t    vs1;
    vreg_t    vd_old;
    logic     valid_o;
    logic     illegal_o;
    regaddr_t vd_addr;
    vreg_t    vd_data;

    integer      seed = 37;
    int unsigned cycle = 0;
    logic        checking;
    expect_t     exp_q[$];
    expect_t     head;

    // OPIVV and OPMVV funct6 encodings
    funct6_t ivv_f6 [21] = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07, 6'h09, 6'h0A,
                             6'h0B, 6'h18, 6'h19, 6'h1A, 6'h1B, 6'h1C, 6'h1D, 6'h1E, 6'h1F,
                             6'h25, 6'h28, 6'h29};
    funct6_t mvv_f6 [4]  = '{6'h25, 6'h27, 6'h24, 6'h26};
    // add, sub, rsub, sll, srl, sra, mslt, msltu, min, maxu
    funct6_t dir_f6 [10] = '{6'h00, 6'h02, 6'h03, 6'h25, 6'h28, 6'h29, 6'h1B, 6'h1A, 6'h05,
                             6'h06};

    valu_top uut (
        .clk       (clk),
        .rst_i     (rst_i),
        .valid_i   (valid_i),
        .insn_i    (insn),
        .vsew_i    (vsew),
        .vs2_i     (vs2),
        .vs1_i     (vs1),
        .vd_old_i  (vd_old),
        .valid_o   (valid_o),
        .illegal_o (illegal_o),
        .vd_addr_o (vd_addr),
        .vd_data_o (vd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

////////////////////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////////////////////

    function automatic expect_t valu_model(input insn_t op_insn, input sew_e sew,
                                           input vreg_t a, input vreg_t b, input vreg_t old);
        expect_t     e;
        funct6_t     f6;
        funct3_t     f3;
        logic [2:0]  sw;
        int          w;
        int          sh;
        logic [63:0] emask;
        logic [63:0] half;
        logic [63:0] x;
        logic [63:0] y;
        logic [63:0] r;
        longint      sx;
        longint      sy;
        logic        is_cmp;
        logic        is_mul;
        logic        hit;
        logic        ok;
        f6 = op_insn[31:26];
        f3 = op_insn[14:12];
        sw = sew;
        e.illegal = 1'b0;
        e.addr    = op_insn[11:7];
        e.data    = '0;
        e.due     = '0;
        if (op_insn[6:0] != OPCODE_OPV || sw > 3'd2) begin
            e.illegal = 1'b1;
            return e;
        end
        w      = 8 << sw;
        emask  = (64'd1 << w) - 64'd1;
        half   = 64'd1 << (w - 1);
        is_cmp = (f3 == 3'b000) && (f6[5:3] == 3'b011);
        is_mul = (f3 == 3'b010);
        ok     = 1'b1;
        // Compares only touch the low mask bits, vd keeps the rest
        if (is_cmp) e.data = old;
        for (int i = 0; i < 64 / w; i++) begin
            x   = (a >> (i * w)) & emask;
            y   = (b >> (i * w)) & emask;
            sx  = longint'((x ^ half) - half);
            sy  = longint'((y ^ half) - half);
            sh  = int'(y & 64'(w - 1));
            r   = '0;
            hit = 1'b0;
            // Key is {funct3, funct6}
            case ({f3, f6})
                9'h000:  r = x + y;
                9'h002:  r = x - y;
                9'h003:  r = y - x;
                9'h004:  r = (x < y) ? x : y;
                9'h005:  r = (sx < sy) ? x : y;
                9'h006:  r = (x > y) ? x : y;
                9'h007:  r = (sx > sy) ? x : y;
                9'h009:  r = x & y;
                9'h00A:  r = x | y;
                9'h00B:  r = x ^ y;
                9'h018:  hit = (x == y);
                9'h019:  hit = (x != y);
                9'h01A:  hit = (x < y);
                9'h01B:  hit = (sx < sy);
                9'h01C:  hit = (x <= y);
                9'h01D:  hit = (sx <= sy);
                9'h01E:  hit = (x > y);
                9'h01F:  hit = (sx > sy);
                9'h025:  r = x << sh;
                9'h028:  r = x >> sh;
                9'h029:  r = 64'(sx >>> sh);
                9'h0A5:  r = x * y;
                9'h0A4:  r = (x * y) >> 8;
                9'h0A6:  r = 64'(sx * longint'(y)) >> 8;
                9'h0A7:  r = 64'(sx * sy) >> 8;
                default: ok = 1'b0;
            endcase
            if (is_cmp) e.data[i] = hit;
            else e.data = e.data | ((r & emask) << (i * w));
        end
        if (!ok || (is_mul && sw != 3'd0)) begin
            e.illegal = 1'b1;
            e.data    = '0;
        end
        return e;
    endfunction

    function automatic insn_t make_insn(input funct6_t f6, input funct3_t f3, input regaddr_t vd);
        return {f6, 1'b1, 5'd2, 5'd1, f3, vd, OPCODE_OPV};
    endfunction

////////////////////////////////////////////////////////////////////////////
// Checks and stimulus
////////////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_vreg(input string name, input vreg_t got, input vreg_t exp);
        if (got !== exp) fail_run($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input regaddr_t got, input regaddr_t exp);
        if (got !== exp) fail_run($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) fail_run($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // Drive on the falling edge, decode samples on the next rising edge
    task automatic issue(input insn_t i_insn, input sew_e i_sew, input vreg_t i_vs2,
                         input vreg_t i_vs1, input vreg_t i_old);
        expect_t e;
        @(negedge clk);
        valid_i = 1'b1;
        insn    = i_insn;
        vsew    = i_sew;
        vs2     = i_vs2;
        vs1     = i_vs1;
        vd_old  = i_old;
        e       = valu_model(i_insn, i_sew, i_vs2, i_vs1, i_old);
        // Three register stages
        e.due   = cycle + 32'd3;
        exp_q.push_back(e);
    endtask

    always @(negedge clk) begin
        if (checking) begin
            if (valid_o !== 1'b1) begin
                check_flag("valid_o", valid_o, 1'b0);
                check_flag("illegal_o", illegal_o, 1'b0);
            end else if (exp_q.size() == 0) begin
                fail_run("valid_o went high with no instruction outstanding");
            end else begin
                head = exp_q.pop_front();
                if (cycle != head.due) begin
                    fail_run($sformatf("Result for vd %0d came at cycle %0d instead of %0d",
                                       head.addr, cycle, head.due));
                end else begin
                    check_flag("illegal_o", illegal_o, head.illegal);
                    check_addr("vd_addr_o", vd_addr, head.addr);
                    check_vreg("vd_data_o", vd_data, head.data);
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_run("Timeout, the test did not finish in the expected time");
    end

    initial begin
        logic [31:0] rnd;
        logic [31:0] rnd2;
        int          k;
        funct6_t     f6;
        funct3_t     f3;
        logic [2:0]  sw3;
        logic [6:0]  opc;
        vreg_t       ra;
        vreg_t       rb;
        vreg_t       rold;
        rst_i    = 1'b1;
        valid_i  = 1'b0;
        insn     = '0;
        vsew     = EW8;
        vs2      = '0;
        vs1      = '0;
        vd_old   = '0;
        checking = 1'b0;
        repeat (10) @(negedge clk);
        rst_i    = 1'b0;
        checking = 1'b1;
        // Outputs must stay low while idle
        repeat (3) @(negedge clk);

        for (int s = 0; s < 3; s++) begin
            for (int j = 0; j < 10; j++) begin
                issue(make_insn(dir_f6[j], F3_OPIVV, 5'(s * 10 + j)), sew_e'(s),
                      DIR_A, DIR_B, VD_FILL);
            end
        end
        issue(make_insn(6'h09, F3_OPIVV, 5'd30), EW8, DIR_A, DIR_B, VD_FILL);
        issue(make_insn(6'h0B, F3_OPIVV, 5'd31), EW8, DIR_A, DIR_B, VD_FILL);
        for (int j = 0; j < 4; j++) begin
            issue(make_insn(mvv_f6[j], F3_OPMVV, 5'(j)), EW8, MUL_A, MUL_B, VD_FILL);
        end

        // Bad opcode, unlisted funct6, reserved vsew, vmul at SEW 16
        issue(make_insn(6'h00, F3_OPIVV, 5'd4) ^ 32'h1, EW8, DIR_A, DIR_B, VD_FILL);
        issue(make_insn(6'h01, F3_OPIVV, 5'd5), EW8, DIR_A, DIR_B, VD_FILL);
        issue(make_insn(6'h00, F3_OPIVV, 5'd6), sew_e'(3'b011), DIR_A, DIR_B, VD_FILL);
        issue(make_insn(6'h25, F3_OPMVV, 5'd7), EW16, MUL_A, MUL_B, VD_FILL);

        for (int n = 0; n < N_RAND; n++) begin
            rnd  = $random(seed);
            rnd2 = $random(seed);
            ra   = {$random(seed), $random(seed)};
            rb   = {$random(seed), $random(seed)};
            rold = {$random(seed), $random(seed)};
            k    = int'(rnd[4:0]);
            if (k < 21) begin
                f6 = ivv_f6[k];
                f3 = F3_OPIVV;
            end else if (k < 25) begin
                f6 = mvv_f6[k - 21];
                f3 = F3_OPMVV;
            end else begin
                f6 = rnd[10:5];
                f3 = rnd[13:11];
            end
            sw3 = (rnd[19:16] == 4'd0) ? {1'b1, rnd[21:20]} : 3'(rnd[23:22] % 2'd3);
            opc = (rnd[31:27] == 5'd0) ? 7'b1010011 : OPCODE_OPV;
            issue({f6, 1'b1, rnd2[4:0], rnd2[9:5], f3, rnd2[14:10], opc}, sew_e'(sw3),
                  ra, rb, rold);
        end

        @(negedge clk);
        valid_i = 1'b0;
        repeat (4) @(negedge clk);
        if (exp_q.size() != 0) begin
            fail_run($sformatf("%0d results never came out of the pipeline", exp_q.size()));
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/valu_pkg.sv
rtl/valu_decode.sv
rtl/valu_lanes.sv
rtl/valu_writeback.sv
rtl/valu_top.sv
sim/valu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= valu_tb
FLIST     ?= flist.f

BUILD_DIR := obj_dir
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FLIST))
BIN       := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a listed source or the file list changes
$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

# Pass or fail is taken from the log
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
